/* design/fp_norm_control.sv */
`timescale 1ns/10ps
`include "fp_params.svh"

module fp_norm_control (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          in_valid,
  input  fp_round_types_pkg::rm_t       in_rm,
  input  logic [`ID_WIDTH-1:0]          in_id,
  input  fp_round_types_pkg::fflags_t   in_fflags,
  output logic                          ld_s1,
  output logic                          ld_s2,
  output fp_round_types_pkg::rm_t       rm_s2,
  output logic [`ID_WIDTH-1:0]          id_s2,
  output fp_round_types_pkg::fflags_t   fflags_s2,
  output logic                          out_valid
);
  import fp_round_types_pkg::*;

  logic                  valid_s1;
  logic                  valid_s2;
  logic [`ID_WIDTH-1:0]  id_s1;

  assign ld_s1     = in_valid;
  assign ld_s2     = valid_s1;
  assign out_valid = valid_s2;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_s1 <= 1'b0;
      valid_s2 <= 1'b0;
    end else begin
      valid_s1 <= in_valid;
      valid_s2 <= valid_s1;
    end
  end

  // Rounding mode and flags feed the rounder while the id rides to the output
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rm_s2     <= RNE;
      fflags_s2 <= '0;
      id_s1     <= '0;
      id_s2     <= '0;
    end else begin
      if (ld_s1) begin
        rm_s2     <= in_rm;
        fflags_s2 <= in_fflags;
        id_s1     <= in_id;
      end
      if (ld_s2) begin
        id_s2 <= id_s1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Pipeline checks

  a_valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
    ##2 (out_valid == $past(in_valid, 2)));

  a_id_known: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> !$isunknown(id_s2));

endmodule

/* design/fp_norm_round_top.sv */
`timescale 1ns/10ps
`include "fp_params.svh"

module fp_norm_round_top (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 in_valid,
  input  fp_norm_types_pkg::fp_word_t          in_word,
  input  logic                                 in_expo_overflow,
  input  logic                                 in_carry,
  input  logic                                 in_safe,
  input  logic                                 in_hidden,
  input  fp_norm_types_pkg::grs_t              in_grs,
  input  fp_norm_types_pkg::fp_shift_amt_t     in_clz,
  input  logic                                 in_subnormal,
  input  logic                                 in_right_shift,
  input  fp_norm_types_pkg::fp_shift_amt_t     in_right_shift_amt,
  input  fp_round_types_pkg::rm_t              in_rm,
  input  logic [`ID_WIDTH-1:0]                 in_id,
  input  fp_round_types_pkg::fflags_t          in_fflags,
  output logic                                 out_valid,
  output fp_norm_types_pkg::fp_word_t          out_word,
  output logic [`ID_WIDTH-1:0]                 out_id,
  output fp_round_types_pkg::fflags_t          out_fflags
);
  import fp_norm_types_pkg::*;
  import fp_round_types_pkg::*;

  fp_normalize_packet_t norm_pkt;
  logic                 ld_s1;
  logic                 ld_s2;
  rm_t                  rm_s2;
  fflags_t              fflags_s2;

  shift_stage_if shift_bus ();
  round_stage_if round_bus ();

  // Pack the unit result
  always_comb begin
    norm_pkt.word            = in_word;
    norm_pkt.expo_overflow   = in_expo_overflow;
    norm_pkt.carry           = in_carry;
    norm_pkt.safe            = in_safe;
    norm_pkt.hidden          = in_hidden;
    norm_pkt.grs             = in_grs;
    norm_pkt.clz             = in_clz;
    norm_pkt.subnormal       = in_subnormal;
    norm_pkt.right_shift     = in_right_shift;
    norm_pkt.right_shift_amt = in_right_shift_amt;
  end

  fp_norm_control u_control (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_rm     (in_rm),
    .in_id     (in_id),
    .in_fflags (in_fflags),
    .ld_s1     (ld_s1),
    .ld_s2     (ld_s2),
    .rm_s2     (rm_s2),
    .id_s2     (out_id),
    .fflags_s2 (fflags_s2),
    .out_valid (out_valid)
  );

  fp_normalize u_normalize (
    .pkt       (norm_pkt),
    .shift_out (shift_bus)
  );

  fp_norm_shifter u_shifter (
    .clk       (clk),
    .rst_n     (rst_n),
    .ld_s1     (ld_s1),
    .shift_in  (shift_bus),
    .round_out (round_bus)
  );

  fp_round u_round (
    .clk       (clk),
    .rst_n     (rst_n),
    .ld_s2     (ld_s2),
    .rm        (rm_s2),
    .fflags_in (fflags_s2),
    .round_in  (round_bus),
    .word      (out_word),
    .fflags    (out_fflags)
  );

endmodule

/* design/fp_norm_shifter.sv */
`timescale 1ns/10ps
`include "fp_params.svh"

module fp_norm_shifter (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          ld_s1,
  shift_stage_if.dst    shift_in,
  round_stage_if.src    round_out
);
  import fp_norm_types_pkg::*;

  fp_shift_packet_t              sp;
  logic                          fill;
  logic signed [`MANT_WIDTH:0]   shift_ext;
  fp_mant_t                      shifted;
  fp_mant_t                      lost_mask;
  logic                          lost_sticky;
  fp_mant_t                      shift_res;
  fp_round_packet_t              round_d;

  assign sp = shift_in.pkt;

  //////////////////////////////////////////////////
  // Barrel shift

  // Reversed input refills from the original sticky bit
  assign fill      = ~sp.right_shift & sp.shifter_in[`MANT_WIDTH-1];
  assign shift_ext = $signed({fill, sp.shifter_in}) >>> sp.shift_amt;
  assign shifted   = shift_ext[`MANT_WIDTH-1:0];

  // Bits pushed out below the sticky position
  assign lost_mask   = ~({`MANT_WIDTH{1'b1}} << sp.shift_amt);
  assign lost_sticky = sp.right_shift & (|(sp.shifter_in & lost_mask));
  assign shift_res   = {shifted[`MANT_WIDTH-1:1], shifted[0] | lost_sticky};

  always_comb begin
    round_d.sign                     = sp.sign_norm;
    round_d.expo                     = sp.expo_norm;
    round_d.expo_overflow            = sp.expo_overflow_norm;
    round_d.mant                     = sp.right_shift ? shift_res : reverse_mant(shift_res);
    round_d.overflow_before_rounding = sp.overflow_before_rounding;
  end

  // Stage 1 register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      round_out.pkt <= '0;
    end else if (ld_s1) begin
      round_out.pkt <= round_d;
    end
  end

  // Leading zero count from the unit stays within the mantissa
  a_left_shift_range: assert property (@(posedge clk) disable iff (!rst_n)
    (ld_s1 && !sp.right_shift) |-> (sp.shift_amt <= `MANT_WIDTH));

endmodule

/* design/fp_norm_types_pkg.sv */
`include "fp_params.svh"

package fp_norm_types_pkg;

  //////////////////////////////////////////////////
  // Word formats

  typedef struct packed {
    logic                   sign;
    logic [`EXPO_WIDTH-1:0] expo;
    logic [`FRAC_WIDTH-1:0] frac;
  } fp_fields_t;

  // Same word, read as raw bits or as fields
  typedef union packed {
    logic [`FLEN-1:0] raw;
    fp_fields_t       f;
  } fp_word_t;

  // Bit 2 guard, bit 1 round, bit 0 sticky
  typedef logic [`GRS_WIDTH-1:0]  grs_t;
  typedef logic [`EXPO_WIDTH-1:0] fp_shift_amt_t;

  // {carry, safe, hidden, frac, grs}
  typedef logic [`MANT_WIDTH-1:0] fp_mant_t;

  //////////////////////////////////////////////////
  // Stage packets

  typedef struct packed {
    fp_word_t      word;
    logic          expo_overflow;
    logic          carry;
    logic          safe;
    logic          hidden;
    grs_t          grs;
    fp_shift_amt_t clz;
    logic          subnormal;
    logic          right_shift;
    fp_shift_amt_t right_shift_amt;
  } fp_normalize_packet_t;

  typedef struct packed {
    logic                   sign_norm;
    logic                   expo_overflow_norm;
    logic [`EXPO_WIDTH-1:0] expo_norm;
    fp_mant_t               shifter_in;
    fp_shift_amt_t          shift_amt;
    logic                   right_shift;
    logic                   overflow_before_rounding;
  } fp_shift_packet_t;

  typedef struct packed {
    logic                   sign;
    logic [`EXPO_WIDTH-1:0] expo;
    logic                   expo_overflow;
    fp_mant_t               mant;
    logic                   overflow_before_rounding;
  } fp_round_packet_t;

  // Bit reversal used to turn a left shift into a right shift
  function automatic fp_mant_t reverse_mant(input fp_mant_t m);
    for (int i = 0; i < `MANT_WIDTH; i++) begin
      reverse_mant[i] = m[`MANT_WIDTH-1-i];
    end
  endfunction

endpackage

/* design/fp_normalize.sv */
`timescale 1ns/10ps
`include "fp_params.svh"

module fp_normalize (
  input fp_norm_types_pkg::fp_normalize_packet_t pkt,
  shift_stage_if.src                            shift_out
);
  import fp_norm_types_pkg::*;

  logic                   sign;
  logic [`EXPO_WIDTH-1:0] expo;
  logic [`FRAC_WIDTH-1:0] frac;
  logic [`EXPO_WIDTH:0]   expo_masked;
  fp_shift_amt_t          rs_shift;
  logic [`EXPO_WIDTH:0]   rs_amt;
  logic [`EXPO_WIDTH:0]   expo_rs;
  logic                   expo_lt_clz;
  logic [`EXPO_WIDTH:0]   expo_ls_diff;
  logic [`EXPO_WIDTH:0]   expo_ls;
  fp_shift_amt_t          ls_amt;
  logic [`EXPO_WIDTH:0]   expo_sel;
  fp_mant_t               mant;
  fp_shift_packet_t       shift_pkt;

  // Input word read as fields
  assign sign = pkt.word.f.sign;
  assign expo = pkt.word.f.expo;
  assign frac = pkt.word.f.frac;

  // Subnormal results start from a zero exponent
  assign expo_masked = {pkt.expo_overflow, expo} & {(`EXPO_WIDTH+1){~pkt.subnormal}};

  //////////////////////////////////////////////////
  // Right shift path

  generate if (`ENABLE_SUBNORMAL) begin : g_full_rshift
    assign rs_shift = pkt.right_shift_amt;
  end else begin : g_short_rshift
    // Normal results never need more than two positions
    assign rs_shift = fp_shift_amt_t'(pkt.right_shift_amt[1:0]);
  end endgenerate

  assign rs_amt  = {1'b0, rs_shift} & {(`EXPO_WIDTH+1){~pkt.subnormal}};
  assign expo_rs = expo_masked + rs_amt;

  //////////////////////////////////////////////////
  // Left shift path

  // Borrow out tells that the leading zeros run past the exponent
  assign {expo_lt_clz, expo_ls_diff} = {1'b0, expo_masked} - {2'b00, pkt.clz};

  // Clamp so the result lands on a subnormal
  assign ls_amt = expo_lt_clz ? expo_masked[`EXPO_WIDTH-1:0] : pkt.clz;

  // A subnormal sum that reached the hidden bit gets promoted
  assign expo_ls = (expo_ls_diff & {(`EXPO_WIDTH+1){~expo_lt_clz}})
                 + (`EXPO_WIDTH+1)'(pkt.subnormal & pkt.hidden);

  //////////////////////////////////////////////////
  // Output selection

  always_comb begin
    expo_sel = pkt.right_shift ? expo_rs : expo_ls;
    mant     = {pkt.carry, pkt.safe, pkt.hidden, frac, pkt.grs};

    shift_pkt.sign_norm          = sign;
    shift_pkt.expo_overflow_norm = expo_sel[`EXPO_WIDTH];
    shift_pkt.expo_norm          = expo_sel[`EXPO_WIDTH-1:0];
    shift_pkt.right_shift        = pkt.right_shift;
    shift_pkt.shift_amt          = pkt.right_shift ? rs_shift : ls_amt;
    // Left shift goes through the shifter reversed
    shift_pkt.shifter_in         = pkt.right_shift ? mant : reverse_mant(mant);
    shift_pkt.overflow_before_rounding = ~pkt.right_shift & (|pkt.clz)
                                       & (expo_sel[`EXPO_WIDTH] | (&expo_sel[`EXPO_WIDTH-1:0]));
  end

  assign shift_out.pkt = shift_pkt;

endmodule

/* design/fp_params.svh */
`ifndef FP_PARAMS_SVH
`define FP_PARAMS_SVH

// Single precision word layout
`define FLEN        32
`define EXPO_WIDTH  8
`define FRAC_WIDTH  23

// Guard, round and sticky bits below the fraction
`define GRS_WIDTH   3

// Instruction id carried beside each result
`define ID_WIDTH    4

// Carry, safe and hidden bits on top of fraction and GRS
`define MANT_WIDTH  (3 + `FRAC_WIDTH + `GRS_WIDTH)

// Allow the full right shift range needed by subnormal results
`define ENABLE_SUBNORMAL 1

`endif

/* design/fp_round.sv */
`timescale 1ns/10ps
`include "fp_params.svh"

module fp_round (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          ld_s2,
  input  fp_round_types_pkg::rm_t       rm,
  input  fp_round_types_pkg::fflags_t   fflags_in,
  round_stage_if.dst                    round_in,
  output fp_norm_types_pkg::fp_word_t   word,
  output fp_round_types_pkg::fflags_t   fflags
);
  import fp_norm_types_pkg::*;
  import fp_round_types_pkg::*;

  fp_round_packet_t         rp;
  logic                     lsb;
  logic                     guard;
  logic                     round_bit;
  logic                     sticky;
  logic                     inexact;
  logic                     round_up;
  logic [`FRAC_WIDTH+1:0]   sig_rnd;
  logic                     sig_carry;
  logic                     promote;
  logic [`EXPO_WIDTH+1:0]   expo_rnd;
  logic [`FRAC_WIDTH-1:0]   frac_rnd;
  logic                     overflow;
  logic                     tiny;
  logic                     to_max;
  fp_word_t                 word_d;
  fflags_t                  flags_d;

  assign rp = round_in.pkt;

  assign lsb                       = rp.mant[`GRS_WIDTH];
  assign {guard, round_bit, sticky} = rp.mant[`GRS_WIDTH-1:0];
  assign inexact                   = guard | round_bit | sticky;

  //////////////////////////////////////////////////
  // Round up decision

  always_comb begin
    case (rm)
      RNE:     round_up = guard & (round_bit | sticky | lsb);
      RTZ:     round_up = 1'b0;
      RDN:     round_up = rp.sign & inexact;
      RUP:     round_up = ~rp.sign & inexact;
      RMM:     round_up = guard;
      default: round_up = 1'b0;
    endcase
  end

  // Hidden bit and fraction plus one carry position
  assign sig_rnd   = {1'b0, rp.mant[`FRAC_WIDTH+`GRS_WIDTH:`GRS_WIDTH]}
                   + (`FRAC_WIDTH+2)'(round_up);
  assign sig_carry = sig_rnd[`FRAC_WIDTH+1];
  // Largest subnormal rounding into the smallest normal
  assign promote   = (rp.expo == '0) & ~rp.mant[`FRAC_WIDTH+`GRS_WIDTH] & sig_rnd[`FRAC_WIDTH];

  assign expo_rnd = {1'b0, rp.expo_overflow, rp.expo} + (`EXPO_WIDTH+2)'(sig_carry | promote);
  assign frac_rnd = sig_carry ? sig_rnd[`FRAC_WIDTH:1] : sig_rnd[`FRAC_WIDTH-1:0];

  //////////////////////////////////////////////////
  // Exceptions and result

  assign overflow = rp.overflow_before_rounding | (|expo_rnd[`EXPO_WIDTH+1:`EXPO_WIDTH])
                  | (&expo_rnd[`EXPO_WIDTH-1:0]);
  assign tiny     = ~overflow & (expo_rnd[`EXPO_WIDTH-1:0] == '0);
  // Modes that round away from infinity saturate to max finite
  assign to_max   = (rm == RTZ) | ((rm == RDN) & ~rp.sign) | ((rm == RUP) & rp.sign);

  always_comb begin
    if (overflow && to_max) begin
      word_d.raw = {rp.sign, {(`EXPO_WIDTH-1){1'b1}}, 1'b0, {`FRAC_WIDTH{1'b1}}};
    end else if (overflow) begin
      word_d.raw = {rp.sign, {`EXPO_WIDTH{1'b1}}, {`FRAC_WIDTH{1'b0}}};
    end else begin
      word_d.raw = {rp.sign, expo_rnd[`EXPO_WIDTH-1:0], frac_rnd};
    end

    flags_d    = fflags_in;
    flags_d.of = fflags_in.of | overflow;
    flags_d.uf = fflags_in.uf | (tiny & inexact);
    flags_d.nx = fflags_in.nx | inexact | overflow;
  end

  // Stage 2 register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word   <= '0;
      fflags <= '0;
    end else if (ld_s2) begin
      word   <= word_d;
      fflags <= flags_d;
    end
  end

endmodule

/* design/fp_round_types_pkg.sv */
package fp_round_types_pkg;

  //////////////////////////////////////////////////
  // RISC-V rounding modes, frm encoding

  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011,
    RMM = 3'b100
  } rm_t;

  //////////////////////////////////////////////////
  // Accrued exception flags, fflags bit order

  typedef struct packed {
    // Invalid operation
    logic nv;
    // Divide by zero
    logic dz;
    // Overflow
    logic of;
    // Underflow
    logic uf;
    // Inexact
    logic nx;
  } fflags_t;

endpackage

/* design/fp_stage_ifs.sv */
`timescale 1ns/10ps

//////////////////////////////////////////////////
// Normalize to shifter, combinational in stage 0

interface shift_stage_if;
  import fp_norm_types_pkg::*;

  // Sign, exponent, shifter input, amount and direction
  fp_shift_packet_t pkt;

  modport src (
    output pkt
  );

  modport dst (
    input pkt
  );
endinterface

//////////////////////////////////////////////////
// Shifter to rounder, registered at the end of stage 1

interface round_stage_if;
  import fp_norm_types_pkg::*;

  // Shifted mantissa with sticky in the LSB
  fp_round_packet_t pkt;

  modport src (
    output pkt
  );

  modport dst (
    input pkt
  );
endinterface

/* files.f */
+incdir+design
+incdir+testbench
design/fp_norm_types_pkg.sv
design/fp_round_types_pkg.sv
design/fp_stage_ifs.sv
design/fp_normalize.sv
design/fp_norm_shifter.sv
design/fp_round.sv
design/fp_norm_control.sv
design/fp_norm_round_top.sv
testbench/tb_fp_norm_round.sv

/* testbench/fp_norm_model.svh */
`ifndef FP_NORM_MODEL_SVH
`define FP_NORM_MODEL_SVH

// Expected rounded word and flags for one unrounded result
function automatic void model_norm_round(
  input  fp_normalize_packet_t p,
  input  rm_t                  rm,
  input  fflags_t              flags_in,
  output fp_word_t             word,
  output fflags_t              flags
);
  logic [63:0]            mant;
  logic [63:0]            sig;
  logic [63:0]            mask;
  logic [`FRAC_WIDTH-1:0] frac;
  int                     expo;
  int                     amt;
  logic                   sign;
  logic                   sticky;
  logic                   obr;
  logic                   inexact;
  logic                   up;
  logic                   carry_out;
  logic                   ovf;
  logic                   to_max;

  mask = (64'd1 << `MANT_WIDTH) - 1;
  mant = {p.carry, p.safe, p.hidden, p.word.f.frac, p.grs};
  sign = p.word.f.sign;
  expo = p.subnormal ? 0 : int'({p.expo_overflow, p.word.f.expo});
  obr  = 1'b0;

  //////////////////////////////////////////////////
  // Normalize

  if (p.right_shift) begin
    amt = (`ENABLE_SUBNORMAL != 0) ? int'(p.right_shift_amt) : int'(p.right_shift_amt[1:0]);
    if (!p.subnormal) begin
      expo = (expo + amt) % 512;
    end
    // Everything at or below the new sticky position folds into it
    if (amt >= `MANT_WIDTH) begin
      sticky = (mant != 0);
      mant   = 0;
    end else begin
      sticky = ((mant & ((64'd1 << (amt + 1)) - 1)) != 0);
      mant   = mant >> amt;
    end
    mant = (mant & ~64'd1) | 64'(sticky);
  end else begin
    if (int'(p.clz) > expo) begin
      amt  = expo;
      expo = 0;
    end else begin
      amt  = int'(p.clz);
      expo = expo - amt;
    end
    expo = (expo + int'(p.subnormal & p.hidden)) % 512;
    obr  = (p.clz != 0) && (expo >= 255);
    // Vacated low bits copy the sticky bit
    if (amt >= `MANT_WIDTH) begin
      mant = mant[0] ? mask : 64'd0;
    end else begin
      mant = ((mant << amt) | (mant[0] ? ((64'd1 << amt) - 1) : 64'd0)) & mask;
    end
  end

  //////////////////////////////////////////////////
  // Round

  inexact = ((mant & 64'd7) != 0);
  case (rm)
    RNE:     up = mant[2] && (mant[1] || mant[0] || mant[3]);
    RTZ:     up = 1'b0;
    RDN:     up = sign && inexact;
    RUP:     up = !sign && inexact;
    default: up = mant[2];
  endcase

  sig       = ((mant >> `GRS_WIDTH) & ((64'd1 << (`FRAC_WIDTH + 1)) - 1)) + 64'(up);
  carry_out = sig[`FRAC_WIDTH+1];
  if (carry_out || ((expo % 256) == 0 && !mant[`FRAC_WIDTH+`GRS_WIDTH] && sig[`FRAC_WIDTH])) begin
    expo = expo + 1;
  end
  frac = carry_out ? sig[`FRAC_WIDTH:1] : sig[`FRAC_WIDTH-1:0];

  ovf    = obr || (expo >= 255);
  to_max = (rm == RTZ) || (rm == RDN && !sign) || (rm == RUP && sign);

  word        = '0;
  word.f.sign = sign;
  if (ovf) begin
    word.f.expo = to_max ? 8'hFE : 8'hFF;
    word.f.frac = to_max ? '1 : '0;
  end else begin
    word.f.expo = expo[`EXPO_WIDTH-1:0];
    word.f.frac = frac;
  end

  flags    = flags_in;
  flags.of = flags_in.of | ovf;
  flags.uf = flags_in.uf | (!ovf && expo == 0 && inexact);
  flags.nx = flags_in.nx | inexact | ovf;
endfunction

`endif

/* testbench/tb_fp_norm_round.sv */
`timescale 1ns/10ps
`include "fp_params.svh"

module tb_fp_norm_round;
  import fp_norm_types_pkg::*;
  import fp_round_types_pkg::*;

  `include "fp_norm_model.svh"

  localparam int TIMEOUT_CYCLES = 20;

  logic                 clk;
  logic                 rst_n;
  logic                 in_valid;
  fp_normalize_packet_t in_pkt;
  rm_t                  in_rm;
  logic [`ID_WIDTH-1:0] in_id;
  fflags_t              in_fflags;
  logic                 out_valid;
  fp_word_t             out_word;
  logic [`ID_WIDTH-1:0] out_id;
  fflags_t              out_fflags;

  // Expected results, oldest first
  fp_word_t             exp_word_q[$];
  fflags_t              exp_flags_q[$];
  logic [`ID_WIDTH-1:0] exp_id_q[$];
  string                exp_name_q[$];
  string                test_name;
  logic                 valid_d1;
  logic                 valid_d2;
  int                   cycles;

  fp_norm_round_top dut0 (
    .clk                (clk),
    .rst_n              (rst_n),
    .in_valid           (in_valid),
    .in_word            (in_pkt.word),
    .in_expo_overflow   (in_pkt.expo_overflow),
    .in_carry           (in_pkt.carry),
    .in_safe            (in_pkt.safe),
    .in_hidden          (in_pkt.hidden),
    .in_grs             (in_pkt.grs),
    .in_clz             (in_pkt.clz),
    .in_subnormal       (in_pkt.subnormal),
    .in_right_shift     (in_pkt.right_shift),
    .in_right_shift_amt (in_pkt.right_shift_amt),
    .in_rm              (in_rm),
    .in_id              (in_id),
    .in_fflags          (in_fflags),
    .out_valid          (out_valid),
    .out_word           (out_word),
    .out_id             (out_id),
    .out_fflags         (out_fflags)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Checking

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_word(input string name, input fp_word_t exp, input fp_word_t act);
    if (act !== exp) begin
      stop_with_error($sformatf("MISMATCH %s word expected %h actual %h", name, exp.raw, act.raw));
    end
  endtask

  task automatic compare_flags(input string name, input fflags_t exp, input fflags_t act);
    if (act !== exp) begin
      stop_with_error($sformatf("MISMATCH %s fflags expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic compare_id(input string name, input logic [`ID_WIDTH-1:0] exp,
                            input logic [`ID_WIDTH-1:0] act);
    if (act !== exp) begin
      stop_with_error($sformatf("MISMATCH %s id expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic compare_valid(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_with_error($sformatf("MISMATCH %s out_valid expected %b actual %b", name, exp, act));
    end
  endtask

  // Advance to the next falling edge and check what the DUT shows there
  task automatic step_cycle();
    string name;
    @(negedge clk);
    valid_d2 = valid_d1;
    valid_d1 = in_valid;
    compare_valid(test_name, valid_d2, out_valid);
    if (out_valid) begin
      if (exp_word_q.size() == 0) begin
        stop_with_error("out_valid went high with no packet in flight");
      end
      name = exp_name_q.pop_front();
      compare_word(name, exp_word_q.pop_front(), out_word);
      compare_flags(name, exp_flags_q.pop_front(), out_fflags);
      compare_id(name, exp_id_q.pop_front(), out_id);
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus

  task automatic send(input fp_normalize_packet_t p, input rm_t rm, input fflags_t flags);
    fp_word_t             w;
    fflags_t              f;
    logic [`ID_WIDTH-1:0] id;
    step_cycle();
    id        = `ID_WIDTH'($urandom);
    in_valid  = 1'b1;
    in_pkt    = p;
    in_rm     = rm;
    in_id     = id;
    in_fflags = flags;
    model_norm_round(p, rm, flags, w, f);
    exp_word_q.push_back(w);
    exp_flags_q.push_back(f);
    exp_id_q.push_back(id);
    exp_name_q.push_back(test_name);
  endtask

  task automatic idle();
    step_cycle();
    in_valid  = 1'b0;
    in_pkt    = '0;
    in_rm     = RNE;
    in_id     = '0;
    in_fflags = '0;
  endtask

  function automatic rm_t random_rm();
    return rm_t'(3'($urandom % 5));
  endfunction

  // Normal number with the hidden bit set and no shift
  function automatic fp_normalize_packet_t base_packet();
    fp_normalize_packet_t p;
    p             = '0;
    p.word.f.sign = 1'($urandom);
    p.word.f.expo = 8'd1 + 8'($urandom % 200);
    p.word.f.frac = 23'($urandom);
    p.hidden      = 1'b1;
    p.grs         = 3'($urandom);
    return p;
  endfunction

  task automatic check_first_latency();
    test_name = "first_packet";
    repeat (3) idle();
    send(base_packet(), RNE, '0);
    cycles = 0;
    do begin
      idle();
      cycles++;
    end while (!out_valid && cycles < TIMEOUT_CYCLES);
    if (!out_valid) begin
      stop_with_error("no output appeared within the timeout after the first packet");
    end
  endtask

  task automatic run_right_shift(input int n);
    fp_normalize_packet_t p;
    test_name = "right_shift";
    repeat (n) begin
      p                 = base_packet();
      p.carry           = 1'($urandom);
      p.safe            = p.carry ? 1'($urandom) : 1'b1;
      p.hidden          = 1'($urandom);
      p.right_shift     = 1'b1;
      p.right_shift_amt = p.carry ? 8'd2 : 8'd1;
      send(p, RNE, '0);
    end
  endtask

  task automatic run_left_shift(input int n);
    fp_normalize_packet_t p;
    test_name = "left_shift";
    repeat (n) begin
      p        = base_packet();
      p.hidden = 1'b0;
      if ($urandom % 2) begin
        p.word.f.expo = 8'd30 + 8'($urandom % 200);
        p.clz         = 8'd1 + 8'($urandom % 23);
      end else begin
        // Leading zeros run past the exponent
        p.word.f.expo = 8'($urandom % 10);
        p.clz         = p.word.f.expo + 8'd1 + 8'($urandom % 12);
      end
      p.subnormal = ($urandom % 8 == 0);
      send(p, random_rm(), '0);
    end
  endtask

  task automatic run_round_modes(input int n);
    fp_normalize_packet_t p;
    test_name = "round_modes";
    repeat (n) begin
      p                 = base_packet();
      p.right_shift     = 1'b1;
      p.right_shift_amt = 8'($urandom % 4);
      send(p, random_rm(), '0);
    end
  endtask

  task automatic run_overflow(input int n);
    fp_normalize_packet_t p;
    test_name = "overflow";
    repeat (n) begin
      p = base_packet();
      case ($urandom % 3)
        0: begin
          p.word.f.expo     = 8'd254 + 8'($urandom % 2);
          p.carry           = 1'b1;
          p.right_shift     = 1'b1;
          p.right_shift_amt = 8'd2;
        end
        1: begin
          p.expo_overflow = 1'b1;
          p.right_shift   = 1'b1;
        end
        default: begin
          // Exponent saturates after the left shift
          p.expo_overflow = 1'b1;
          p.word.f.expo   = 8'd10 + 8'($urandom % 200);
          p.clz           = 8'd1 + 8'($urandom % 8);
        end
      endcase
      send(p, random_rm(), '0);
    end
  endtask

  task automatic run_back_to_back(input int n);
    fp_normalize_packet_t p;
    test_name = "back_to_back";
    repeat (n) begin
      p               = base_packet();
      p.word.f.expo   = 8'($urandom);
      p.expo_overflow = ($urandom % 8 == 0);
      p.carry         = 1'($urandom);
      p.safe          = 1'($urandom);
      p.hidden        = 1'($urandom);
      p.subnormal     = ($urandom % 8 == 0);
      p.right_shift   = 1'($urandom);
      if (p.right_shift) begin
        p.right_shift_amt = 8'($urandom % 40);
      end else begin
        p.clz = 8'($urandom % 30);
      end
      send(p, random_rm(), fflags_t'(5'($urandom)));
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence

  initial begin
    void'($urandom(6));
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_pkt    = '0;
    in_rm     = RNE;
    in_id     = '0;
    in_fflags = '0;
    valid_d1  = 1'b0;
    valid_d2  = 1'b0;
    test_name = "reset";
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    check_first_latency();
    run_right_shift(60);
    run_left_shift(80);
    run_round_modes(100);
    run_overflow(60);
    run_back_to_back(300);

    test_name = "drain";
    cycles    = 0;
    while (exp_word_q.size() != 0 && cycles < TIMEOUT_CYCLES) begin
      idle();
      cycles++;
    end
    if (exp_word_q.size() != 0) begin
      stop_with_error($sformatf("%0d packets never came out", exp_word_q.size()));
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule
